// File: common/pci_master_settings.svh
`ifndef PCI_MASTER_SETTINGS_SVH
`define PCI_MASTER_SETTINGS_SVH

// write data buffer holds 1 << 10 = 1024 words
`define PCI_MST_DBUF_AW 10

// depth of the AW and AR command queues and the length queue
`define PCI_MST_CMDQ_AW 3

// depth of the B and R return queues
`define PCI_MST_RESPQ_AW 3

`endif

// File: common/pci_axi_pkg.sv
package pci_axi_pkg;

	// transaction ID shared by AW, AR, B and R
	typedef logic [3:0] axi_id_t;

	// byte address of a burst
	typedef logic [63:0] axi_addr_t;

	// burst length in beats minus one
	typedef logic [7:0] axi_len_t;

	typedef logic [31:0] axi_data_t;

	typedef logic [3:0] axi_strb_t;

	// OKAY, EXOKAY, SLVERR, DECERR
	typedef logic [1:0] axi_resp_t;

endpackage

// File: common/pci_cmd_pkg.sv
package pci_cmd_pkg;

	// completion error from the PCI engine, encoded like an AXI response
	typedef logic [1:0] cmd_err_t;

	// which path owns the command port
	typedef enum logic {
		own_write = 1'b0,
		own_read  = 1'b1
	} arb_owner_t;

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DATA_W = 8,
	parameter int ADDR_W = 3
) (
	input  logic              mst_s_aclk,
	input  logic              mst_s_aresetn,
	input  logic              wr_en,
	input  logic [DATA_W-1:0] din,
	input  logic              rd_en,
	output logic [DATA_W-1:0] dout,
	output logic              full,
	output logic              empty
);
	localparam int DEPTH = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [0:DEPTH-1];
	logic [ADDR_W:0]   wr_ptr;
	logic [ADDR_W:0]   rd_ptr;
	logic              push;
	logic              pop;

	assign push = wr_en && !full;
	assign pop  = rd_en && !empty;

	// the top pointer bit tells a full queue from an empty one
	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	// head word is visible without a read request
	assign dout = mem[rd_ptr[ADDR_W-1:0]];

	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge mst_s_aclk) begin
		if (push)
			mem[wr_ptr[ADDR_W-1:0]] <= din;
	end

endmodule

// File: pci_master_wpath/pci_master_wpath.sv
`timescale 1ns/1ps
`include "pci_master_settings.svh"

module pci_master_wpath (
	input  logic                           mst_s_aclk,
	input  logic                           mst_s_aresetn,
	input  pci_axi_pkg::axi_id_t           mst_s_awid,
	input  pci_axi_pkg::axi_addr_t         mst_s_awaddr,
	input  pci_axi_pkg::axi_len_t          mst_s_awlen,
	input  logic                           mst_s_awvalid,
	output logic                           mst_s_awready,
	input  pci_axi_pkg::axi_data_t         mst_s_wdata,
	input  pci_axi_pkg::axi_strb_t         mst_s_wstrb,
	input  logic                           mst_s_wlast,
	input  logic                           mst_s_wvalid,
	output logic                           mst_s_wready,
	output pci_axi_pkg::axi_id_t           mst_s_bid,
	output pci_axi_pkg::axi_resp_t         mst_s_bresp,
	output logic                           mst_s_bvalid,
	input  logic                           mst_s_bready,
	input  logic [`PCI_MST_DBUF_AW-1:0]    data_idx,
	output pci_axi_pkg::axi_data_t         data_dout,
	output pci_axi_pkg::axi_strb_t         data_strb,
	output logic                           wcmd_valid,
	output pci_axi_pkg::axi_id_t           wcmd_id,
	output pci_axi_pkg::axi_addr_t         wcmd_addr,
	output pci_axi_pkg::axi_len_t          wcmd_len,
	input  logic                           wcmd_ready,
	input  logic                           wresp_valid,
	input  pci_axi_pkg::axi_id_t           wresp_id,
	input  pci_axi_pkg::axi_len_t          wresp_len,
	input  pci_cmd_pkg::cmd_err_t          wresp_err,
	output logic                           wresp_ready
);
	localparam int PW = `PCI_MST_DBUF_AW + 1;

	logic                   rdy_en;
	logic                   addr_full;
	logic                   addr_empty;
	logic                   len_full;
	logic                   len_empty;
	logic                   resp_full;
	logic                   resp_empty;
	logic                   buf_full;
	logic                   w_fire;
	logic                   cmd_fire;
	logic                   b_fire;
	logic [PW-1:0]          wr_idx;
	logic [PW-1:0]          rd_idx;
	logic [PW-1:0]          buf_used;
	pci_axi_pkg::axi_len_t  beat_cnt;
	pci_axi_pkg::axi_len_t  b_len;
	pci_cmd_pkg::cmd_err_t  b_err;
	logic [$bits(pci_axi_pkg::axi_strb_t)+$bits(pci_axi_pkg::axi_data_t)-1:0]
		dbuf [0:(1<<`PCI_MST_DBUF_AW)-1];

	// ready outputs come up on the first edge after reset release
	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn)
			rdy_en <= 1'b0;
		else
			rdy_en <= 1'b1;
	end

	// burst length comes from counting W beats, awlen is not trusted
	assign mst_s_awready = rdy_en && !addr_full;
	assign buf_used = wr_idx - rd_idx;
	assign buf_full = buf_used[PW-1];
	assign mst_s_wready = rdy_en && !buf_full && !len_full;
	assign w_fire = mst_s_wvalid && mst_s_wready;

	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			wr_idx   <= '0;
			beat_cnt <= '0;
		end else if (w_fire) begin
			wr_idx   <= wr_idx + 1'b1;
			beat_cnt <= mst_s_wlast ? '0 : beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge mst_s_aclk) begin
		if (w_fire)
			dbuf[wr_idx[PW-2:0]] <= {mst_s_wstrb, mst_s_wdata};
	end

	assign {data_strb, data_dout} = dbuf[data_idx];

	sync_fifo #(.DATA_W(68), .ADDR_W(`PCI_MST_CMDQ_AW)) addr_fifo_i (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.wr_en(mst_s_awvalid && mst_s_awready), .din({mst_s_awid, mst_s_awaddr}),
		.rd_en(cmd_fire), .dout({wcmd_id, wcmd_addr}),
		.full(addr_full), .empty(addr_empty)
	);

	sync_fifo #(.DATA_W(8), .ADDR_W(`PCI_MST_CMDQ_AW)) len_fifo_i (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.wr_en(w_fire && mst_s_wlast), .din(beat_cnt),
		.rd_en(cmd_fire), .dout(wcmd_len),
		.full(len_full), .empty(len_empty)
	);

	// a command needs both its address and its finished data burst
	assign wcmd_valid = !addr_empty && !len_empty;
	assign cmd_fire = wcmd_valid && wcmd_ready;

	assign wresp_ready = rdy_en && !resp_full;

	sync_fifo #(.DATA_W(14), .ADDR_W(`PCI_MST_RESPQ_AW)) resp_fifo_i (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.wr_en(wresp_valid && wresp_ready), .din({wresp_err, wresp_id, wresp_len}),
		.rd_en(b_fire), .dout({b_err, mst_s_bid, b_len}),
		.full(resp_full), .empty(resp_empty)
	);

	assign mst_s_bvalid = !resp_empty;
	assign mst_s_bresp = b_err;
	assign b_fire = mst_s_bvalid && mst_s_bready;

	// a completed burst gives its buffer words back
	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn)
			rd_idx <= '0;
		else if (b_fire)
			rd_idx <= rd_idx + PW'(b_len) + 1'b1;
	end

endmodule

// File: pci_master_rpath/pci_master_rpath.sv
`timescale 1ns/1ps
`include "pci_master_settings.svh"

module pci_master_rpath (
	input  logic                   mst_s_aclk,
	input  logic                   mst_s_aresetn,
	input  pci_axi_pkg::axi_id_t   mst_s_arid,
	input  pci_axi_pkg::axi_addr_t mst_s_araddr,
	input  pci_axi_pkg::axi_len_t  mst_s_arlen,
	input  logic                   mst_s_arvalid,
	output logic                   mst_s_arready,
	output pci_axi_pkg::axi_id_t   mst_s_rid,
	output pci_axi_pkg::axi_data_t mst_s_rdata,
	output pci_axi_pkg::axi_resp_t mst_s_rresp,
	output logic                   mst_s_rlast,
	output logic                   mst_s_rvalid,
	input  logic                   mst_s_rready,
	output logic                   rcmd_valid,
	output pci_axi_pkg::axi_id_t   rcmd_id,
	output pci_axi_pkg::axi_addr_t rcmd_addr,
	output pci_axi_pkg::axi_len_t  rcmd_len,
	input  logic                   rcmd_ready,
	input  logic                   rdat_valid,
	input  pci_axi_pkg::axi_id_t   rdat_id,
	input  pci_axi_pkg::axi_data_t rdat_data,
	input  pci_cmd_pkg::cmd_err_t  rdat_err,
	input  logic                   rdat_last,
	output logic                   rdat_ready
);
	logic                  rdy_en;
	logic                  cmd_full;
	logic                  cmd_empty;
	logic                  beat_full;
	logic                  beat_empty;
	pci_cmd_pkg::cmd_err_t r_err;

	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn)
			rdy_en <= 1'b0;
		else
			rdy_en <= 1'b1;
	end

	assign mst_s_arready = rdy_en && !cmd_full;

	// each AR request becomes one read command unchanged
	sync_fifo #(.DATA_W(76), .ADDR_W(`PCI_MST_CMDQ_AW)) cmd_fifo_i (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.wr_en(mst_s_arvalid && mst_s_arready),
		.din({mst_s_arid, mst_s_araddr, mst_s_arlen}),
		.rd_en(rcmd_valid && rcmd_ready), .dout({rcmd_id, rcmd_addr, rcmd_len}),
		.full(cmd_full), .empty(cmd_empty)
	);

	assign rcmd_valid = !cmd_empty;

	assign rdat_ready = rdy_en && !beat_full;

	// returned beats wait here until the master takes them on R
	sync_fifo #(.DATA_W(39), .ADDR_W(`PCI_MST_RESPQ_AW)) beat_fifo_i (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.wr_en(rdat_valid && rdat_ready),
		.din({rdat_id, rdat_data, rdat_err, rdat_last}),
		.rd_en(mst_s_rvalid && mst_s_rready),
		.dout({mst_s_rid, mst_s_rdata, r_err, mst_s_rlast}),
		.full(beat_full), .empty(beat_empty)
	);

	assign mst_s_rvalid = !beat_empty;
	assign mst_s_rresp = r_err;

endmodule

// File: rtl/pci_cmd_arb.sv
`timescale 1ns/1ps

module pci_cmd_arb (
	input  logic                   mst_s_aclk,
	input  logic                   mst_s_aresetn,
	input  logic                   wcmd_valid,
	input  pci_axi_pkg::axi_id_t   wcmd_id,
	input  pci_axi_pkg::axi_addr_t wcmd_addr,
	input  pci_axi_pkg::axi_len_t  wcmd_len,
	output logic                   wcmd_ready,
	input  logic                   rcmd_valid,
	input  pci_axi_pkg::axi_id_t   rcmd_id,
	input  pci_axi_pkg::axi_addr_t rcmd_addr,
	input  pci_axi_pkg::axi_len_t  rcmd_len,
	output logic                   rcmd_ready,
	output logic                   cmd_valid,
	output logic                   cmd_write,
	output pci_axi_pkg::axi_id_t   cmd_id,
	output pci_axi_pkg::axi_addr_t cmd_addr,
	output pci_axi_pkg::axi_len_t  cmd_len,
	input  logic                   cmd_ready
);
	pci_cmd_pkg::arb_owner_t owner;
	pci_cmd_pkg::arb_owner_t grant;
	logic                    stalled;

	// a stalled command keeps the port, otherwise the path not served last wins
	always_comb begin
		if (stalled)
			grant = owner;
		else if (wcmd_valid && rcmd_valid)
			grant = (owner == pci_cmd_pkg::own_write) ?
				pci_cmd_pkg::own_read : pci_cmd_pkg::own_write;
		else if (wcmd_valid)
			grant = pci_cmd_pkg::own_write;
		else
			grant = pci_cmd_pkg::own_read;
	end

	assign cmd_write  = grant == pci_cmd_pkg::own_write;
	assign cmd_valid  = cmd_write ? wcmd_valid : rcmd_valid;
	assign cmd_id     = cmd_write ? wcmd_id : rcmd_id;
	assign cmd_addr   = cmd_write ? wcmd_addr : rcmd_addr;
	assign cmd_len    = cmd_write ? wcmd_len : rcmd_len;
	assign wcmd_ready = cmd_ready && cmd_write;
	assign rcmd_ready = cmd_ready && !cmd_write;

	// starting as read owner lets the first contested grant go to writes
	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			owner   <= pci_cmd_pkg::own_read;
			stalled <= 1'b0;
		end else if (cmd_valid) begin
			owner   <= grant;
			stalled <= !cmd_ready;
		end else begin
			stalled <= 1'b0;
		end
	end

endmodule

// File: rtl/pci_master.sv
`timescale 1ns/1ps
`include "pci_master_settings.svh"

module pci_master (
	input  logic                        mst_s_aclk,
	input  logic                        mst_s_aresetn,
	input  pci_axi_pkg::axi_id_t        mst_s_awid,
	input  pci_axi_pkg::axi_addr_t      mst_s_awaddr,
	input  pci_axi_pkg::axi_len_t       mst_s_awlen,
	input  logic                        mst_s_awvalid,
	output logic                        mst_s_awready,
	input  pci_axi_pkg::axi_data_t      mst_s_wdata,
	input  pci_axi_pkg::axi_strb_t      mst_s_wstrb,
	input  logic                        mst_s_wlast,
	input  logic                        mst_s_wvalid,
	output logic                        mst_s_wready,
	output pci_axi_pkg::axi_id_t        mst_s_bid,
	output pci_axi_pkg::axi_resp_t      mst_s_bresp,
	output logic                        mst_s_bvalid,
	input  logic                        mst_s_bready,
	input  pci_axi_pkg::axi_id_t        mst_s_arid,
	input  pci_axi_pkg::axi_addr_t      mst_s_araddr,
	input  pci_axi_pkg::axi_len_t       mst_s_arlen,
	input  logic                        mst_s_arvalid,
	output logic                        mst_s_arready,
	output pci_axi_pkg::axi_id_t        mst_s_rid,
	output pci_axi_pkg::axi_data_t      mst_s_rdata,
	output pci_axi_pkg::axi_resp_t      mst_s_rresp,
	output logic                        mst_s_rlast,
	output logic                        mst_s_rvalid,
	input  logic                        mst_s_rready,
	input  logic [`PCI_MST_DBUF_AW-1:0] data_idx,
	output pci_axi_pkg::axi_data_t      data_dout,
	output pci_axi_pkg::axi_strb_t      data_strb,
	output logic                        cmd_valid,
	output logic                        cmd_write,
	output pci_axi_pkg::axi_id_t        cmd_id,
	output pci_axi_pkg::axi_addr_t      cmd_addr,
	output pci_axi_pkg::axi_len_t       cmd_len,
	input  logic                        cmd_ready,
	input  logic                        wresp_valid,
	input  pci_axi_pkg::axi_id_t        wresp_id,
	input  pci_axi_pkg::axi_len_t       wresp_len,
	input  pci_cmd_pkg::cmd_err_t       wresp_err,
	output logic                        wresp_ready,
	input  logic                        rdat_valid,
	input  pci_axi_pkg::axi_id_t        rdat_id,
	input  pci_axi_pkg::axi_data_t      rdat_data,
	input  pci_cmd_pkg::cmd_err_t       rdat_err,
	input  logic                        rdat_last,
	output logic                        rdat_ready
);
	// commands offered by each path to the arbiter
	logic                   wcmd_valid;
	pci_axi_pkg::axi_id_t   wcmd_id;
	pci_axi_pkg::axi_addr_t wcmd_addr;
	pci_axi_pkg::axi_len_t  wcmd_len;
	logic                   wcmd_ready;
	logic                   rcmd_valid;
	pci_axi_pkg::axi_id_t   rcmd_id;
	pci_axi_pkg::axi_addr_t rcmd_addr;
	pci_axi_pkg::axi_len_t  rcmd_len;
	logic                   rcmd_ready;

	pci_master_wpath pci_master_wpath_i (.*);

	pci_master_rpath pci_master_rpath_i (.*);

	pci_cmd_arb pci_cmd_arb_i (.*);

endmodule

// File: testbench/tb_pci_master.sv
`timescale 1ns/1ps
`include "pci_master_settings.svh"

module tb_pci_master;
	localparam int NROWS = 14;
	localparam bit OP_WR = 1'b1;
	localparam bit OP_RD = 1'b0;

	logic                               mst_s_aclk;
	logic                               mst_s_aresetn;
	pci_axi_pkg::axi_id_t               mst_s_awid;
	pci_axi_pkg::axi_addr_t             mst_s_awaddr;
	pci_axi_pkg::axi_len_t              mst_s_awlen;
	logic                               mst_s_awvalid;
	logic                               mst_s_awready;
	pci_axi_pkg::axi_data_t             mst_s_wdata;
	pci_axi_pkg::axi_strb_t             mst_s_wstrb;
	logic                               mst_s_wlast;
	logic                               mst_s_wvalid;
	logic                               mst_s_wready;
	pci_axi_pkg::axi_id_t               mst_s_bid;
	pci_axi_pkg::axi_resp_t             mst_s_bresp;
	logic                               mst_s_bvalid;
	logic                               mst_s_bready;
	pci_axi_pkg::axi_id_t               mst_s_arid;
	pci_axi_pkg::axi_addr_t             mst_s_araddr;
	pci_axi_pkg::axi_len_t              mst_s_arlen;
	logic                               mst_s_arvalid;
	logic                               mst_s_arready;
	pci_axi_pkg::axi_id_t               mst_s_rid;
	pci_axi_pkg::axi_data_t             mst_s_rdata;
	pci_axi_pkg::axi_resp_t             mst_s_rresp;
	logic                               mst_s_rlast;
	logic                               mst_s_rvalid;
	logic                               mst_s_rready;
	logic [`PCI_MST_DBUF_AW-1:0]        data_idx;
	pci_axi_pkg::axi_data_t             data_dout;
	pci_axi_pkg::axi_strb_t             data_strb;
	logic                               cmd_valid;
	logic                               cmd_write;
	pci_axi_pkg::axi_id_t               cmd_id;
	pci_axi_pkg::axi_addr_t             cmd_addr;
	pci_axi_pkg::axi_len_t              cmd_len;
	logic                               cmd_ready;
	logic                               wresp_valid;
	pci_axi_pkg::axi_id_t               wresp_id;
	pci_axi_pkg::axi_len_t              wresp_len;
	pci_cmd_pkg::cmd_err_t              wresp_err;
	logic                               wresp_ready;
	logic                               rdat_valid;
	pci_axi_pkg::axi_id_t               rdat_id;
	pci_axi_pkg::axi_data_t             rdat_data;
	pci_cmd_pkg::cmd_err_t              rdat_err;
	logic                               rdat_last;
	logic                               rdat_ready;

	// stimulus table, one row per burst
	bit                     t_op   [NROWS];
	pci_axi_pkg::axi_id_t   t_id   [NROWS];
	pci_axi_pkg::axi_addr_t t_addr [NROWS];
	pci_axi_pkg::axi_len_t  t_len  [NROWS];
	pci_axi_pkg::axi_data_t t_base [NROWS];
	pci_cmd_pkg::cmd_err_t  t_err  [NROWS];

	int        nrows_added;
	int        wr_rows[$];
	int        rd_rows[$];
	int        wserve[$];
	int        rserve[$];
	int        errors;
	int        tests_done;
	int        contested;
	int        wlast_row;
	bit        run;
	logic [15:0] lfsr;

	pci_master pci_master_i (.*);

	initial begin
		mst_s_aclk = 1'b0;
		forever #10 mst_s_aclk = ~mst_s_aclk;
	end

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
		$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_text(string msg);
		$display("** Error at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic add_row(bit op, pci_axi_pkg::axi_id_t id, pci_axi_pkg::axi_addr_t addr,
		pci_axi_pkg::axi_len_t len, pci_axi_pkg::axi_data_t base, pci_cmd_pkg::cmd_err_t err);
		t_op[nrows_added]   = op;
		t_id[nrows_added]   = id;
		t_addr[nrows_added] = addr;
		t_len[nrows_added]  = len;
		t_base[nrows_added] = base;
		t_err[nrows_added]  = err;
		nrows_added++;
	endtask

	task automatic check_idle_outputs();
		if (cmd_valid || mst_s_bvalid || mst_s_rvalid || wresp_ready || rdat_ready ||
			mst_s_awready || mst_s_wready || mst_s_arready)
			report_text("an output valid or ready is high around reset");
	endtask

	initial begin
		mst_s_aresetn = 1'b0;
		mst_s_awid = '0;
		mst_s_awaddr = '0;
		mst_s_awlen = '0;
		mst_s_awvalid = 1'b0;
		mst_s_wdata = '0;
		mst_s_wstrb = '0;
		mst_s_wlast = 1'b0;
		mst_s_wvalid = 1'b0;
		mst_s_bready = 1'b0;
		mst_s_arid = '0;
		mst_s_araddr = '0;
		mst_s_arlen = '0;
		mst_s_arvalid = 1'b0;
		mst_s_rready = 1'b0;
		data_idx = '0;
		cmd_ready = 1'b0;
		wresp_valid = 1'b0;
		wresp_id = '0;
		wresp_len = '0;
		wresp_err = '0;
		rdat_valid = 1'b0;
		rdat_id = '0;
		rdat_data = '0;
		rdat_err = '0;
		rdat_last = 1'b0;
		lfsr = 16'd71;
		errors = 0;
		tests_done = 0;
		contested = 0;
		wlast_row = -1;
		nrows_added = 0;
		run = 1'b0;

		// write lengths add up to 1075 words so the buffer index wraps
		add_row(OP_WR, 4'h1, 64'h0000_0001_1000_0000, 8'd255, 32'h1000_0000, 2'd0);
		add_row(OP_RD, 4'h2, 64'h0000_0000_0000_2000, 8'd7,   32'h0, 2'd0);
		add_row(OP_WR, 4'h3, 64'h0000_0002_2000_0040, 8'd200, 32'h2200_0000, 2'd2);
		add_row(OP_RD, 4'h4, 64'h0000_0003_0000_4100, 8'd3,   32'h0, 2'd2);
		add_row(OP_WR, 4'h5, 64'h0000_0000_3000_0000, 8'd255, 32'h3300_0000, 2'd0);
		add_row(OP_RD, 4'h6, 64'h0000_0000_0000_6000, 8'd15,  32'h0, 2'd0);
		add_row(OP_WR, 4'h7, 64'h0000_0004_4000_0080, 8'd255, 32'h4400_0000, 2'd3);
		add_row(OP_RD, 4'h8, 64'h0000_0000_0000_8000, 8'd0,   32'h0, 2'd1);
		add_row(OP_WR, 4'h9, 64'h0000_0000_5000_0000, 8'd100, 32'h5500_0000, 2'd0);
		add_row(OP_RD, 4'hA, 64'h0000_0005_0000_A000, 8'd5,   32'h0, 2'd0);
		add_row(OP_WR, 4'hB, 64'h0000_0000_6000_0000, 8'd0,   32'h6600_0000, 2'd1);
		add_row(OP_RD, 4'hC, 64'h0000_0000_0000_C000, 8'd2,   32'h0, 2'd3);
		add_row(OP_WR, 4'hD, 64'h0000_0000_7000_0000, 8'd3,   32'h7700_0000, 2'd0);
		add_row(OP_RD, 4'hE, 64'h0000_0000_0000_E000, 8'd1,   32'h0, 2'd0);
		for (int r = 0; r < NROWS; r++) begin
			if (t_op[r] == OP_WR)
				wr_rows.push_back(r);
			else
				rd_rows.push_back(r);
		end

		repeat (10) begin
			@(negedge mst_s_aclk);
			check_idle_outputs();
		end
		mst_s_aresetn = 1'b1;
		#1;
		check_idle_outputs();
		$display("reset test done");
		run = 1'b1;

		while (tests_done < NROWS)
			@(posedge mst_s_aclk);
		repeat (5) @(posedge mst_s_aclk);
		if (contested == 0)
			report_text("no cycle offered a write and a read command together");
		$display("arbitration test done, %0d contested grants checked", contested);
		$display("%0d tests finished, %0d errors", tests_done, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		repeat (200 * NROWS + 100) @(posedge mst_s_aclk);
		$display("watchdog expired with %0d of %0d tests finished", tests_done, NROWS);
		$display("Some tests failed");
		$finish;
	end

	initial begin : write_driver
		wait (run);
		for (int r = 0; r < NROWS; r++) begin
			if (t_op[r] == OP_WR) begin
				@(negedge mst_s_aclk);
				mst_s_awvalid = 1'b1;
				mst_s_awid = t_id[r];
				mst_s_awaddr = t_addr[r];
				mst_s_awlen = t_len[r];
				do @(posedge mst_s_aclk); while (!mst_s_awready);
				@(negedge mst_s_aclk);
				mst_s_awvalid = 1'b0;
				for (int k = 0; k <= int'(t_len[r]); k++) begin
					if (k > 0)
						@(negedge mst_s_aclk);
					mst_s_wvalid = 1'b1;
					mst_s_wdata = t_base[r] + k;
					mst_s_wstrb = mst_s_wdata[3:0];
					mst_s_wlast = k == int'(t_len[r]);
					if (mst_s_wlast)
						wlast_row = r;
					do @(posedge mst_s_aclk); while (!mst_s_wready);
				end
				@(negedge mst_s_aclk);
				mst_s_wvalid = 1'b0;
				mst_s_wlast = 1'b0;
			end
		end
	end

	// each read request goes out with the last W beat of the write before it
	// so that both commands reach the arbiter in the same cycle
	initial begin : read_driver
		wait (run);
		for (int r = 0; r < NROWS; r++) begin
			if (t_op[r] == OP_RD) begin
				wait (wlast_row >= r - 1);
				mst_s_arvalid = 1'b1;
				mst_s_arid = t_id[r];
				mst_s_araddr = t_addr[r];
				mst_s_arlen = t_len[r];
				do @(posedge mst_s_aclk); while (!mst_s_arready);
				@(negedge mst_s_aclk);
				mst_s_arvalid = 1'b0;
			end
		end
	end

	// PCI engine model, command port side
	initial begin : cmd_accept
		logic                   stall_prev;
		logic                   last_dir;
		logic                   have_last;
		logic                   both;
		logic                   s_write;
		pci_axi_pkg::axi_id_t   s_id;
		pci_axi_pkg::axi_addr_t s_addr;
		pci_axi_pkg::axi_len_t  s_len;
		int                     wi;
		int                     ri;
		int                     r;
		stall_prev = 1'b0;
		have_last = 1'b0;
		last_dir = 1'b0;
		wi = 0;
		ri = 0;
		wait (run);
		forever begin
			@(negedge mst_s_aclk);
			cmd_ready = rand_bit();
			@(posedge mst_s_aclk);
			both = pci_master_i.wcmd_valid && pci_master_i.rcmd_valid;
			if (stall_prev) begin
				if (!cmd_valid)
					report_text("cmd_valid dropped while a command was stalled");
				if (cmd_write !== s_write || cmd_id !== s_id || cmd_addr !== s_addr ||
					cmd_len !== s_len)
					report_text("stalled command changed its fields");
			end
			// a fresh grant between two waiting paths goes to the one not served last
			if (both && !stall_prev && have_last) begin
				contested++;
				if (cmd_write == last_dir)
					report_value("cmd_write", cmd_write, !last_dir);
			end
			if (cmd_valid && cmd_ready) begin
				last_dir = cmd_write;
				have_last = 1'b1;
				if (cmd_write && wi >= wr_rows.size()) begin
					report_text("write command accepted with no write left in the table");
				end else if (!cmd_write && ri >= rd_rows.size()) begin
					report_text("read command accepted with no read left in the table");
				end else begin
					r = cmd_write ? wr_rows[wi] : rd_rows[ri];
					if (cmd_id !== t_id[r])
						report_value("cmd_id", cmd_id, t_id[r]);
					if (cmd_addr !== t_addr[r])
						report_value("cmd_addr", cmd_addr, t_addr[r]);
					if (cmd_len !== t_len[r])
						report_value("cmd_len", cmd_len, t_len[r]);
					if (cmd_write) begin
						wi++;
						wserve.push_back(r);
					end else begin
						ri++;
						rserve.push_back(r);
					end
				end
				stall_prev = 1'b0;
			end else if (cmd_valid) begin
				stall_prev = 1'b1;
				s_write = cmd_write;
				s_id = cmd_id;
				s_addr = cmd_addr;
				s_len = cmd_len;
			end else begin
				stall_prev = 1'b0;
			end
		end
	end

	// PCI engine model, reads each burst from the buffer then completes it
	initial begin : write_engine
		logic [`PCI_MST_DBUF_AW-1:0] base;
		pci_axi_pkg::axi_data_t      exp_data;
		int                          r;
		base = '0;
		forever begin
			while (wserve.size() == 0)
				@(posedge mst_s_aclk);
			r = wserve.pop_front();
			for (int k = 0; k <= int'(t_len[r]); k++) begin
				@(negedge mst_s_aclk);
				data_idx = base + (`PCI_MST_DBUF_AW)'(k);
				@(posedge mst_s_aclk);
				exp_data = t_base[r] + k;
				if (data_dout !== exp_data)
					report_value("data_dout", data_dout, exp_data);
				if (data_strb !== exp_data[3:0])
					report_value("data_strb", data_strb, exp_data[3:0]);
			end
			base = base + (`PCI_MST_DBUF_AW)'(t_len[r]) + 1'b1;
			while (rand_bit())
				@(negedge mst_s_aclk);
			@(negedge mst_s_aclk);
			wresp_valid = 1'b1;
			wresp_id = t_id[r];
			wresp_len = t_len[r];
			wresp_err = t_err[r];
			do @(posedge mst_s_aclk); while (!wresp_ready);
			@(negedge mst_s_aclk);
			wresp_valid = 1'b0;
		end
	end

	// PCI engine model, returns read data as address plus beat number
	initial begin : read_engine
		int r;
		forever begin
			while (rserve.size() == 0)
				@(posedge mst_s_aclk);
			r = rserve.pop_front();
			while (rand_bit())
				@(negedge mst_s_aclk);
			for (int k = 0; k <= int'(t_len[r]); k++) begin
				@(negedge mst_s_aclk);
				rdat_valid = 1'b1;
				rdat_id = t_id[r];
				rdat_data = t_addr[r][31:0] + k;
				rdat_err = t_err[r];
				rdat_last = k == int'(t_len[r]);
				do @(posedge mst_s_aclk); while (!rdat_ready);
			end
			@(negedge mst_s_aclk);
			rdat_valid = 1'b0;
			rdat_last = 1'b0;
		end
	end

	initial begin : b_check
		int bi;
		int r;
		bi = 0;
		wait (run);
		forever begin
			@(negedge mst_s_aclk);
			mst_s_bready = rand_bit();
			@(posedge mst_s_aclk);
			if (mst_s_bvalid && mst_s_bready) begin
				if (bi >= wr_rows.size()) begin
					report_text("B response arrived with no write outstanding");
				end else begin
					r = wr_rows[bi];
					bi++;
					if (mst_s_bid !== t_id[r])
						report_value("mst_s_bid", mst_s_bid, t_id[r]);
					if (mst_s_bresp !== t_err[r])
						report_value("mst_s_bresp", mst_s_bresp, t_err[r]);
					$display("test %0d write id %0h, %0d beats done", r, t_id[r],
						int'(t_len[r]) + 1);
					tests_done++;
				end
			end
		end
	end

	initial begin : r_check
		int                     ri;
		int                     beat;
		int                     r;
		pci_axi_pkg::axi_data_t exp_data;
		ri = 0;
		beat = 0;
		wait (run);
		forever begin
			@(negedge mst_s_aclk);
			mst_s_rready = rand_bit();
			@(posedge mst_s_aclk);
			if (mst_s_rvalid && mst_s_rready) begin
				if (ri >= rd_rows.size()) begin
					report_text("R beat arrived with no read outstanding");
				end else begin
					r = rd_rows[ri];
					exp_data = t_addr[r][31:0] + beat;
					if (mst_s_rid !== t_id[r])
						report_value("mst_s_rid", mst_s_rid, t_id[r]);
					if (mst_s_rdata !== exp_data)
						report_value("mst_s_rdata", mst_s_rdata, exp_data);
					if (mst_s_rresp !== t_err[r])
						report_value("mst_s_rresp", mst_s_rresp, t_err[r]);
					if (mst_s_rlast !== (beat == int'(t_len[r])))
						report_value("mst_s_rlast", mst_s_rlast, beat == int'(t_len[r]));
					if (beat == int'(t_len[r])) begin
						$display("test %0d read id %0h, %0d beats done", r, t_id[r], beat + 1);
						tests_done++;
						ri++;
						beat = 0;
					end else begin
						beat++;
					end
				end
			end
		end
	end

endmodule

// File: compile.f
+incdir+common
common/pci_axi_pkg.sv
common/pci_cmd_pkg.sv
rtl/sync_fifo.sv
pci_master_wpath/pci_master_wpath.sv
pci_master_rpath/pci_master_rpath.sv
rtl/pci_cmd_arb.sv
rtl/pci_master.sv
testbench/tb_pci_master.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_pci_master
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
